/* Makefile */
VERILATOR ?= verilator
TOP       ?= ifid_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
BFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
logic/ifid_pkg.sv
logic/instr_decoder.sv
logic/ifid_regs.sv
logic/ifid_top.sv
tests/tb_clock.sv
tests/ifid_tb.sv

/* logic/ifid_pkg.sv */
/*
 * IF/ID stage shared definitions
 * opcode encoding, decoded control flags and datapath widths
 */
`default_nettype none

package ifid_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    parameter int instr_width        = 16;  // instruction word
    parameter int data_width         = 8;   // operand and immediate
    parameter int reg_addr_width     = 3;   // eight integer registers
    parameter int branch_field_width = 10;  // jump field, instr[9:0]

    ////////////////////////////////////////
    // opcodes, instr[15:11]
    ////////////////////////////////////////
    typedef enum logic [4:0] {
        op_nop     = 5'h00,
        op_add     = 5'h01,
        op_sub     = 5'h02,
        op_and     = 5'h03,
        op_or      = 5'h04,
        op_not     = 5'h05,
        op_shl     = 5'h06,
        op_jmp     = 5'h07,
        op_rload   = 5'h08,  // load from data memory
        op_rstore  = 5'h09,  // store to data memory, source in dest field
        op_andbit  = 5'h0a,
        op_orbit   = 5'h0b,
        op_notbit  = 5'h0c,
        op_compare = 5'h0d,
        op_jmpgt   = 5'h0e,
        op_jmplt   = 5'h0f,
        op_jmpeq   = 5'h10,
        op_jmpc    = 5'h11,
        op_ldi     = 5'h12,  // load 8-bit immediate
        op_output  = 5'h1a,
        op_input   = 5'h1b
    } opcode_t;

    // decoded control word, one bit per action
    typedef struct packed {
        logic add_op, and_op, or_op, not_op;      // alu word ops
        logic and_bit, or_bit, not_bit;           // alu bitwise ops
        logic shift_left, logic_op;
        logic carry_in, op2_complement, compare;  // subtract and compare
        logic jump, jump_uncond;
        logic jump_gt, jump_lt, jump_eq, jump_carry;
        logic load, store, reg_write, ld_imm;     // memory and write-back
        logic out_op, in_op;                      // port access
    } ctrl_t;

endpackage

`default_nettype wire

/* logic/ifid_regs.sv */
/*
 * IF/ID pipeline register
 * holds one decoded instruction plus its forwarded operands for execute
 */
`default_nettype none

module ifid_regs #(
    parameter int pc_width = 10
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                branch_taken,  // from execute
    input  wire ifid_pkg::ctrl_t                     ctrl,
    input  wire logic [ifid_pkg::reg_addr_width-1:0] op1_addr,
    input  wire logic [ifid_pkg::reg_addr_width-1:0] op2_addr,
    input  wire logic [ifid_pkg::reg_addr_width-1:0] op3_addr,
    input  wire logic [ifid_pkg::reg_addr_width-1:0] res_addr,
    input  wire logic [ifid_pkg::data_width-1:0]     imm,
    input  wire logic [pc_width-1:0]                 target,
    input  wire logic [ifid_pkg::data_width-1:0]     op1_data,
    input  wire logic [ifid_pkg::data_width-1:0]     op2_data,
    input  wire logic [ifid_pkg::data_width-1:0]     op3_data,
    output ifid_pkg::ctrl_t                          ctrl_q,
    output logic      [ifid_pkg::data_width-1:0]     imm_q,
    output logic      [pc_width-1:0]                 target_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op1_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op2_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op3_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] res_addr_q,
    output logic      [ifid_pkg::data_width-1:0]     op1_q,
    output logic      [ifid_pkg::data_width-1:0]     op2_q,
    output logic      [ifid_pkg::data_width-1:0]     op3_q,
    output logic                                     squash_q  // kill this slot in execute
);

    // captures every cycle, no stall
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_q     <= '0;  // no flag active after reset
            imm_q      <= '0;
            target_q   <= '0;
            op1_addr_q <= '0;
            op2_addr_q <= '0;
            op3_addr_q <= '0;
            res_addr_q <= '0;
            op1_q      <= '0;
            op2_q      <= '0;
            op3_q      <= '0;
            squash_q   <= 1'b0;
        end
        else
        begin
            ctrl_q     <= ctrl;
            imm_q      <= imm;
            target_q   <= target;
            op1_addr_q <= op1_addr;
            op2_addr_q <= op2_addr;
            op3_addr_q <= op3_addr;
            res_addr_q <= res_addr;   // already zero for store
            op1_q      <= op1_data;   // forwarded operands
            op2_q      <= op2_data;
            op3_q      <= op3_data;
            squash_q   <= branch_taken;  // taken branch kills the fetched slot
        end
    end

endmodule

`default_nettype wire

/* logic/ifid_top.sv */
/*
 * IF/ID stage top, decoder feeding the stage register
 */
`default_nettype none

module ifid_top #(
    parameter int pc_width = 10  // 1 to 10
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic [ifid_pkg::instr_width-1:0]    instr,         // from instruction memory
    input  wire logic                                branch_taken,
    input  wire logic [ifid_pkg::data_width-1:0]     op1_data,      // from forwarding unit
    input  wire logic [ifid_pkg::data_width-1:0]     op2_data,
    input  wire logic [ifid_pkg::data_width-1:0]     op3_data,
    // same-cycle outputs to forwarding unit
    output logic      [ifid_pkg::reg_addr_width-1:0] op1_addr,
    output logic      [ifid_pkg::reg_addr_width-1:0] op2_addr,
    output logic      [ifid_pkg::reg_addr_width-1:0] op3_addr,
    output logic                                     load_flag,
    // registered outputs to execute
    output ifid_pkg::ctrl_t                          ctrl_q,
    output logic      [ifid_pkg::data_width-1:0]     imm_q,
    output logic      [pc_width-1:0]                 target_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op1_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op2_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] op3_addr_q,
    output logic      [ifid_pkg::reg_addr_width-1:0] res_addr_q,
    output logic      [ifid_pkg::data_width-1:0]     op1_q,
    output logic      [ifid_pkg::data_width-1:0]     op2_q,
    output logic      [ifid_pkg::data_width-1:0]     op3_q,
    output logic                                     squash_q
);

    ////////////////////////////////////////
    // decoder to register
    ////////////////////////////////////////
    ifid_pkg::ctrl_t                     ctrl;
    logic [ifid_pkg::reg_addr_width-1:0] res_addr;
    logic [ifid_pkg::data_width-1:0]     imm;
    logic [pc_width-1:0]                 target;

    instr_decoder #(.pc_width(pc_width)) u_dec (
        .instr     (instr),
        .ctrl      (ctrl),
        .op1_addr  (op1_addr),
        .op2_addr  (op2_addr),
        .op3_addr  (op3_addr),
        .res_addr  (res_addr),
        .load_flag (load_flag),
        .imm       (imm),
        .target    (target)
    );

    ifid_regs #(.pc_width(pc_width)) u_regs (
        .clk          (clk),
        .rst          (rst),
        .branch_taken (branch_taken),
        .ctrl         (ctrl),
        .op1_addr     (op1_addr),
        .op2_addr     (op2_addr),
        .op3_addr     (op3_addr),
        .res_addr     (res_addr),
        .imm          (imm),
        .target       (target),
        .op1_data     (op1_data),
        .op2_data     (op2_data),
        .op3_data     (op3_data),
        .ctrl_q       (ctrl_q),
        .imm_q        (imm_q),
        .target_q     (target_q),
        .op1_addr_q   (op1_addr_q),
        .op2_addr_q   (op2_addr_q),
        .op3_addr_q   (op3_addr_q),
        .res_addr_q   (res_addr_q),
        .op1_q        (op1_q),
        .op2_q        (op2_q),
        .op3_q        (op3_q),
        .squash_q     (squash_q)
    );

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
/*
 * Instruction decoder for the IF/ID stage
 * turns a 16-bit instruction into control flags and operand fields
 */
`default_nettype none

module instr_decoder #(
    parameter int pc_width = 10  // low bits of the jump field used as target
) (
    input  wire logic [ifid_pkg::instr_width-1:0]    instr,
    output ifid_pkg::ctrl_t                          ctrl,
    output logic      [ifid_pkg::reg_addr_width-1:0] op1_addr,
    output logic      [ifid_pkg::reg_addr_width-1:0] op2_addr,
    output logic      [ifid_pkg::reg_addr_width-1:0] op3_addr,
    output logic      [ifid_pkg::reg_addr_width-1:0] res_addr,
    output logic                                     load_flag,
    output logic      [ifid_pkg::data_width-1:0]     imm,
    output logic      [pc_width-1:0]                 target
);

    ////////////////////////////////////////
    // field extraction
    ////////////////////////////////////////
    ifid_pkg::opcode_t                         opcode;
    logic [ifid_pkg::reg_addr_width-1:0]       dest_field;    // instr[10:8]
    logic [ifid_pkg::branch_field_width-1:0]   branch_field;  // instr[9:0]

    assign opcode       = ifid_pkg::opcode_t'(instr[15:11]);
    assign dest_field   = instr[10:8];
    assign branch_field = instr[ifid_pkg::branch_field_width-1:0];

    assign op1_addr  = instr[2:0];
    assign op2_addr  = instr[6:4];
    assign imm       = instr[ifid_pkg::data_width-1:0];  // also port number for in/out
    assign load_flag = ctrl.load;                        // forwarding unit needs it early

    // destination is a source register for store and output
    assign op3_addr = (ctrl.store || ctrl.out_op) ? dest_field : '0;
    assign res_addr = ctrl.store ? '0 : dest_field;

    // target only meaningful for jumps
    assign target = ctrl.jump ? branch_field[pc_width-1:0] : '0;

    ////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////
    always_comb
    begin
        ctrl = '0;  // nop and anything unknown
        case (opcode)
            ifid_pkg::op_add:
            begin
                ctrl.add_op    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_sub:
            begin
                ctrl.add_op         = 1'b1;
                ctrl.carry_in       = 1'b1;  // a + ~b + 1
                ctrl.op2_complement = 1'b1;
                ctrl.reg_write      = 1'b1;
            end
            ifid_pkg::op_and:
            begin
                ctrl.and_op    = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_or:
            begin
                ctrl.or_op     = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_not:
            begin
                ctrl.not_op    = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_shl:
            begin
                ctrl.shift_left = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            ifid_pkg::op_andbit:
            begin
                ctrl.and_bit   = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_orbit:
            begin
                ctrl.or_bit    = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_notbit:
            begin
                ctrl.not_bit   = 1'b1;
                ctrl.logic_op  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_compare:
            begin
                // same subtract path, flags only, no write-back
                ctrl.add_op         = 1'b1;
                ctrl.carry_in       = 1'b1;
                ctrl.op2_complement = 1'b1;
                ctrl.compare        = 1'b1;
            end
            ifid_pkg::op_jmp:
            begin
                ctrl.jump        = 1'b1;
                ctrl.jump_uncond = 1'b1;
            end
            ifid_pkg::op_jmpgt:
            begin
                ctrl.jump    = 1'b1;
                ctrl.jump_gt = 1'b1;
            end
            ifid_pkg::op_jmplt:
            begin
                ctrl.jump    = 1'b1;
                ctrl.jump_lt = 1'b1;
            end
            ifid_pkg::op_jmpeq:
            begin
                ctrl.jump    = 1'b1;
                ctrl.jump_eq = 1'b1;
            end
            ifid_pkg::op_jmpc:
            begin
                ctrl.jump       = 1'b1;
                ctrl.jump_carry = 1'b1;
            end
            ifid_pkg::op_rload:
            begin
                ctrl.load      = 1'b1;  // address from op2:op1 registers
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_rstore:  ctrl.store     = 1'b1;
            ifid_pkg::op_ldi:
            begin
                ctrl.ld_imm    = 1'b1;  // execute passes imm as result
                ctrl.reg_write = 1'b1;
            end
            ifid_pkg::op_output:  ctrl.out_op    = 1'b1;
            ifid_pkg::op_input:
            begin
                ctrl.in_op     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default:              ctrl           = '0;  // nop, unused codes
        endcase
    end

endmodule

`default_nettype wire

/* tests/ifid_tb.sv */
/*
 * IF/ID stage testbench
 * random instructions checked against a reference decoder and the one-cycle register
 */
`default_nettype none

module ifid_tb;

    localparam int pc_width    = 10;
    localparam int test_cycles = 1500;
    localparam int max_cycles  = test_cycles + test_cycles / 3;  // room for reset and drain

    // expected decode of one instruction
    typedef struct packed {
        ifid_pkg::ctrl_t                     ctrl;
        logic [ifid_pkg::reg_addr_width-1:0] op1_addr;
        logic [ifid_pkg::reg_addr_width-1:0] op2_addr;
        logic [ifid_pkg::reg_addr_width-1:0] op3_addr;
        logic [ifid_pkg::reg_addr_width-1:0] res_addr;
        logic                                load_flag;
        logic [ifid_pkg::data_width-1:0]     imm;
        logic [pc_width-1:0]                 target;
    } expect_t;

    logic                                clk;
    logic                                rst;
    logic [ifid_pkg::instr_width-1:0]    instr;
    logic                                branch_taken;
    logic [ifid_pkg::data_width-1:0]     op1_data;
    logic [ifid_pkg::data_width-1:0]     op2_data;
    logic [ifid_pkg::data_width-1:0]     op3_data;
    logic [ifid_pkg::reg_addr_width-1:0] op1_addr;
    logic [ifid_pkg::reg_addr_width-1:0] op2_addr;
    logic [ifid_pkg::reg_addr_width-1:0] op3_addr;
    logic                                load_flag;
    ifid_pkg::ctrl_t                     ctrl_q;
    logic [ifid_pkg::data_width-1:0]     imm_q;
    logic [pc_width-1:0]                 target_q;
    logic [ifid_pkg::reg_addr_width-1:0] op1_addr_q;
    logic [ifid_pkg::reg_addr_width-1:0] op2_addr_q;
    logic [ifid_pkg::reg_addr_width-1:0] op3_addr_q;
    logic [ifid_pkg::reg_addr_width-1:0] res_addr_q;
    logic [ifid_pkg::data_width-1:0]     op1_q;
    logic [ifid_pkg::data_width-1:0]     op2_q;
    logic [ifid_pkg::data_width-1:0]     op3_q;
    logic                                squash_q;

    logic [31:0]                         rnd;          // xorshift state
    int                                  cycle_count = 0;
    logic                                running;      // comparator enable
    expect_t                             cur_exp;
    expect_t                             prev_exp;     // what the register should show now
    logic                                prev_branch;
    logic [ifid_pkg::data_width-1:0]     prev_op1;
    logic [ifid_pkg::data_width-1:0]     prev_op2;
    logic [ifid_pkg::data_width-1:0]     prev_op3;

    tb_clock #(.period(4), .reset_cycles(5)) clk_gen0 (.clk(clk), .rst(rst));

    ifid_top #(.pc_width(pc_width)) dut0 (
        .clk(clk), .rst(rst), .instr(instr), .branch_taken(branch_taken),
        .op1_data(op1_data), .op2_data(op2_data), .op3_data(op3_data),
        .op1_addr(op1_addr), .op2_addr(op2_addr), .op3_addr(op3_addr),
        .load_flag(load_flag), .ctrl_q(ctrl_q), .imm_q(imm_q), .target_q(target_q),
        .op1_addr_q(op1_addr_q), .op2_addr_q(op2_addr_q), .op3_addr_q(op3_addr_q),
        .res_addr_q(res_addr_q), .op1_q(op1_q), .op2_q(op2_q), .op3_q(op3_q),
        .squash_q(squash_q)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // integer set is 0x00..0x12 plus output 0x1a and input 0x1b
    function automatic logic is_kept(input logic [4:0] op);
        return (op <= 5'h12) || (op == 5'h1a) || (op == 5'h1b);
    endfunction

    function automatic expect_t ref_decode(input logic [ifid_pkg::instr_width-1:0] w);
        expect_t    e;
        logic [4:0] op;
        e  = '0;
        op = w[15:11];
        case (op)  // one distinguishing flag per opcode
            ifid_pkg::op_add:     e.ctrl.add_op      = 1'b1;
            ifid_pkg::op_and:     e.ctrl.and_op      = 1'b1;
            ifid_pkg::op_or:      e.ctrl.or_op       = 1'b1;
            ifid_pkg::op_not:     e.ctrl.not_op      = 1'b1;
            ifid_pkg::op_andbit:  e.ctrl.and_bit     = 1'b1;
            ifid_pkg::op_orbit:   e.ctrl.or_bit      = 1'b1;
            ifid_pkg::op_notbit:  e.ctrl.not_bit     = 1'b1;
            ifid_pkg::op_shl:     e.ctrl.shift_left  = 1'b1;
            ifid_pkg::op_compare: e.ctrl.compare     = 1'b1;
            ifid_pkg::op_jmp:     e.ctrl.jump_uncond = 1'b1;
            ifid_pkg::op_jmpgt:   e.ctrl.jump_gt     = 1'b1;
            ifid_pkg::op_jmplt:   e.ctrl.jump_lt     = 1'b1;
            ifid_pkg::op_jmpeq:   e.ctrl.jump_eq     = 1'b1;
            ifid_pkg::op_jmpc:    e.ctrl.jump_carry  = 1'b1;
            ifid_pkg::op_rload:   e.ctrl.load        = 1'b1;
            ifid_pkg::op_rstore:  e.ctrl.store       = 1'b1;
            ifid_pkg::op_ldi:     e.ctrl.ld_imm      = 1'b1;
            ifid_pkg::op_output:  e.ctrl.out_op      = 1'b1;
            ifid_pkg::op_input:   e.ctrl.in_op       = 1'b1;
            default:              e.ctrl             = '0;  // nop and rns codes
        endcase
        // subtract path shared by sub and compare
        if (op == ifid_pkg::op_sub || op == ifid_pkg::op_compare)
        begin
            e.ctrl.add_op         = 1'b1;
            e.ctrl.carry_in       = 1'b1;
            e.ctrl.op2_complement = 1'b1;
        end
        e.ctrl.logic_op  = e.ctrl.and_op | e.ctrl.or_op | e.ctrl.not_op
                         | e.ctrl.and_bit | e.ctrl.or_bit | e.ctrl.not_bit;
        e.ctrl.jump      = e.ctrl.jump_uncond | e.ctrl.jump_gt | e.ctrl.jump_lt
                         | e.ctrl.jump_eq | e.ctrl.jump_carry;
        e.ctrl.reg_write = (e.ctrl.add_op & ~e.ctrl.compare) | e.ctrl.logic_op
                         | e.ctrl.shift_left | e.ctrl.load | e.ctrl.ld_imm | e.ctrl.in_op;
        e.op1_addr  = w[2:0];
        e.op2_addr  = w[6:4];
        e.op3_addr  = (e.ctrl.store || e.ctrl.out_op) ? w[10:8] : '0;
        e.res_addr  = e.ctrl.store ? '0 : w[10:8];
        e.load_flag = e.ctrl.load;
        e.imm       = w[7:0];
        e.target    = e.ctrl.jump ? w[pc_width-1:0] : '0;  // zero on non-jumps
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, want);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // registered side right after reset
    task automatic check_reset_state();
        check_value("ctrl_q after reset", 32'(ctrl_q), 32'd0);
        check_value("imm_q after reset", 32'(imm_q), 32'd0);
        check_value("target_q after reset", 32'(target_q), 32'd0);
        check_value("op1_addr_q after reset", 32'(op1_addr_q), 32'd0);
        check_value("op2_addr_q after reset", 32'(op2_addr_q), 32'd0);
        check_value("op3_addr_q after reset", 32'(op3_addr_q), 32'd0);
        check_value("res_addr_q after reset", 32'(res_addr_q), 32'd0);
        check_value("op1_q after reset", 32'(op1_q), 32'd0);
        check_value("op2_q after reset", 32'(op2_q), 32'd0);
        check_value("op3_q after reset", 32'(op3_q), 32'd0);
        check_value("squash_q after reset", 32'(squash_q), 32'd0);
    endtask

    task automatic drive_random();
        logic want_dropped;
        rnd          = xorshift32(rnd);
        want_dropped = (rnd[31:28] == 4'h0);  // about one in sixteen
        rnd          = xorshift32(rnd);
        while (is_kept(rnd[15:11]) == want_dropped)
            rnd = xorshift32(rnd);  // redraw until the opcode class fits
        instr        = rnd[15:0];
        rnd          = xorshift32(rnd);
        op1_data     = rnd[7:0];
        op2_data     = rnd[15:8];
        op3_data     = rnd[23:16];
        branch_taken = rnd[27];
    endtask

    ////////////////////////////////////////
    // comparator at mid-cycle when all is settled
    ////////////////////////////////////////
    always @(negedge clk)
    begin
        if (running)
        begin
            cur_exp = ref_decode(instr);
            check_value("op1_addr", 32'(op1_addr), 32'(cur_exp.op1_addr));
            check_value("op2_addr", 32'(op2_addr), 32'(cur_exp.op2_addr));
            check_value("op3_addr", 32'(op3_addr), 32'(cur_exp.op3_addr));
            check_value("load_flag", 32'(load_flag), 32'(cur_exp.load_flag));
            // register shows the instruction sampled at the last edge
            check_value("ctrl_q", 32'(ctrl_q), 32'(prev_exp.ctrl));
            check_value("imm_q", 32'(imm_q), 32'(prev_exp.imm));
            check_value("target_q", 32'(target_q), 32'(prev_exp.target));
            check_value("op1_addr_q", 32'(op1_addr_q), 32'(prev_exp.op1_addr));
            check_value("op2_addr_q", 32'(op2_addr_q), 32'(prev_exp.op2_addr));
            check_value("op3_addr_q", 32'(op3_addr_q), 32'(prev_exp.op3_addr));
            check_value("res_addr_q", 32'(res_addr_q), 32'(prev_exp.res_addr));
            check_value("op1_q", 32'(op1_q), 32'(prev_op1));
            check_value("op2_q", 32'(op2_q), 32'(prev_op2));
            check_value("op3_q", 32'(op3_q), 32'(prev_op3));
            check_value("squash_q", 32'(squash_q), 32'(prev_branch));
            prev_exp    = cur_exp;
            prev_branch = branch_taken;
            prev_op1    = op1_data;
            prev_op2    = op2_data;
            prev_op3    = op3_data;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial
    begin
        rnd          = 32'hcdd;
        instr        = '0;
        branch_taken = 1'b0;
        op1_data     = '0;
        op2_data     = '0;
        op3_data     = '0;
        running      = 1'b0;
        prev_exp     = '0;  // reset state of the register
        prev_branch  = 1'b0;
        prev_op1     = '0;
        prev_op2     = '0;
        prev_op3     = '0;
        @(negedge rst);     // one unit after an edge
        check_reset_state();
        running = 1'b1;
        for (int i = 0; i < test_cycles; i++)
        begin
            drive_random();
            @(posedge clk);
            #1;
        end
        @(negedge clk);     // last instruction seen on the register outputs
        #1;
        running = 1'b0;
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
/*
 * testbench clock and reset source
 */
`default_nettype none

module tb_clock #(
    parameter int period       = 4,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // sync reset, released just after an edge like the other inputs
    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire
